// ==== sublane_pkg.sv ====
package sublane_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////
    localparam int VLANE_NUM       = 8;
    localparam int MAX_VL_PER_LANE = 256;
    localparam int MEM_DEPTH       = 512;            // VRF words per lane
    localparam int ADDR_W          = $clog2(MEM_DEPTH);
    localparam int VL_W            = $clog2(VLANE_NUM * MAX_VL_PER_LANE) + 1;
    localparam int ELEM_W          = $clog2(MAX_VL_PER_LANE);

    //////////////////////////////
    // Encodings
    //////////////////////////////
    typedef enum logic [2:0] {
        INST_NORMAL = 3'd0,
        INST_STORE  = 3'd2
    } inst_type_e;

    typedef enum logic [1:0] {
        SEW_BYTE = 2'd0,
        SEW_HALF = 2'd1,
        SEW_WORD = 2'd2
    } sew_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ISSUE = 2'd1,
        ST_DRAIN = 2'd2                                // Waiting for writes in flight
    } seq_state_e;

    // One vector instruction as seen by the sequencer
    typedef struct packed {
        inst_type_e        inst_type;
        sew_e              sew;
        logic [VL_W-1:0]   vl;
        logic [ADDR_W-1:0] raddr1;
        logic [ADDR_W-1:0] raddr2;
        logic [ADDR_W-1:0] waddr;
        logic              vector_mask;
    } vec_cmd_t;

    // Pending write for one element position
    typedef struct packed {
        logic                 valid;
        logic [ELEM_W-1:0]    elem;
        logic [VLANE_NUM-1:0] lane_mask;
    } wr_token_t;

    // Packed VRF word holding element elem
    function automatic logic [ADDR_W-1:0] word_offset(sew_e sew, logic [ELEM_W-1:0] elem);
        case (sew)
            SEW_BYTE: return ADDR_W'(elem >> 2);       // Four per word
            SEW_HALF: return ADDR_W'(elem >> 1);
            default:  return ADDR_W'(elem);
        endcase
    endfunction

endpackage

// ==== element_sequencer.sv ====
`timescale 1ns/1ps

module element_sequencer #(
    parameter int PIPE_DELAY = 4
) (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 start_i,
    input  sublane_pkg::vec_cmd_t                cmd_i,
    output logic                                 ready_o,
    output sublane_pkg::vec_cmd_t                act_cmd_o,
    output logic                                 rd_valid_o,
    output logic [sublane_pkg::VLANE_NUM-1:0]    rd_lane_valid_o,
    output logic [sublane_pkg::ADDR_W-1:0]       raddr1_o,
    output logic [sublane_pkg::ADDR_W-1:0]       raddr2_o,
    output logic                                 store_valid_o,
    output sublane_pkg::wr_token_t               issue_tok_o
);

    import sublane_pkg::*;

    localparam int LANE_SH = $clog2(VLANE_NUM);
    localparam int DRAIN_W = (PIPE_DELAY > 1) ? $clog2(PIPE_DELAY) : 1;

    seq_state_e           state_q;
    vec_cmd_t             act_cmd_q;
    logic [ELEM_W:0]      n_elem_q;                  // Elements per lane, up to 256
    logic [ELEM_W-1:0]    elem_cnt_q;
    logic [DRAIN_W-1:0]   drain_cnt_q;
    logic [VL_W-1:0]      vl_round;
    logic                 accept;
    logic                 last_elem;
    logic [VLANE_NUM-1:0] lane_valid;

    assign accept    = start_i && ready_o;
    assign vl_round  = cmd_i.vl + VL_W'(VLANE_NUM - 1);
    assign last_elem = ({1'b0, elem_cnt_q} == n_elem_q - 1'b1);

    //////////////////////////////
    // Command capture
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (accept) begin
            act_cmd_q <= cmd_i;
            n_elem_q  <= vl_round[LANE_SH +: ELEM_W + 1];   // ceil(vl / lanes)
        end
    end

    //////////////////////////////
    // FSM and counters
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q     <= ST_IDLE;
            elem_cnt_q  <= '0;
            drain_cnt_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q    <= ST_ISSUE;
                        elem_cnt_q <= '0;
                    end
                end
                ST_ISSUE: begin
                    if (last_elem) begin
                        // Stores have nothing left to write back
                        state_q     <= (act_cmd_q.inst_type == INST_NORMAL) ? ST_DRAIN : ST_IDLE;
                        drain_cnt_q <= '0;
                    end else begin
                        elem_cnt_q <= elem_cnt_q + 1'b1;
                    end
                end
                ST_DRAIN: begin
                    if (drain_cnt_q == DRAIN_W'(PIPE_DELAY - 1)) begin
                        state_q <= ST_IDLE;                 // Last write just left the pipe
                    end else begin
                        drain_cnt_q <= drain_cnt_q + 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Read side outputs
    //////////////////////////////
    always_comb begin
        for (int l = 0; l < VLANE_NUM; l++) begin
            lane_valid[l] = (VL_W'({elem_cnt_q, LANE_SH'(l)}) < act_cmd_q.vl);
        end
    end

    assign ready_o         = (state_q == ST_IDLE);
    assign act_cmd_o       = act_cmd_q;
    assign rd_valid_o      = (state_q == ST_ISSUE);
    assign rd_lane_valid_o = lane_valid & {VLANE_NUM{rd_valid_o}};
    assign raddr1_o        = act_cmd_q.raddr1 + word_offset(act_cmd_q.sew, elem_cnt_q);
    assign raddr2_o        = act_cmd_q.raddr2 + word_offset(act_cmd_q.sew, elem_cnt_q);
    assign store_valid_o   = rd_valid_o && (act_cmd_q.inst_type == INST_STORE);

    // Write token leaves together with the read
    always_comb begin
        issue_tok_o.valid     = rd_valid_o && (act_cmd_q.inst_type == INST_NORMAL);
        issue_tok_o.elem      = elem_cnt_q;
        issue_tok_o.lane_mask = rd_lane_valid_o;
    end

    // Busy means the captured command must hold
    a_cmd_stable_busy: assert property (@(posedge clk_i) disable iff (!rst_i)
        !ready_o |=> $stable(act_cmd_o));

    a_no_read_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        (state_q == ST_IDLE) |-> !rd_valid_o);

endmodule

// ==== write_delay_line.sv ====
`timescale 1ns/1ps

module write_delay_line #(
    parameter int PIPE_DELAY = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  sublane_pkg::wr_token_t tok_i,
    output sublane_pkg::wr_token_t tok_o
);

    import sublane_pkg::*;

    wr_token_t stage_q [PIPE_DELAY];     // Stage 0 is the newest

    //////////////////////////////
    // Execute latency model
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < PIPE_DELAY; i++) begin
                stage_q[i].valid <= 1'b0;
            end
        end else begin
            stage_q[0] <= tok_i;
            for (int i = 1; i < PIPE_DELAY; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign tok_o = stage_q[PIPE_DELAY-1];

    // Elements come out in order, one per cycle within a burst
    a_elem_order: assert property (@(posedge clk_i) disable iff (!rst_i)
        tok_o.valid && $past(tok_o.valid) |->
            tok_o.elem == ELEM_W'($past(tok_o.elem) + 1'b1));

endmodule

// ==== write_port_gen.sv ====
`timescale 1ns/1ps

module write_port_gen (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  sublane_pkg::vec_cmd_t                   act_cmd_i,
    input  sublane_pkg::wr_token_t                  tok_i,
    output logic                                    wen_o,
    output logic [sublane_pkg::ADDR_W-1:0]          waddr_o,
    output logic [sublane_pkg::VLANE_NUM-1:0][3:0]  bwen_o,
    output logic                                    vmrf_wen_o,
    output logic [sublane_pkg::ELEM_W-1:0]          vmrf_addr_o
);

    import sublane_pkg::*;

    logic [3:0] be_pattern;

    //////////////////////////////
    // Byte-enable pattern
    //////////////////////////////
    always_comb begin
        case (act_cmd_i.sew)
            SEW_BYTE: be_pattern = 4'b0001 << tok_i.elem[1:0];
            SEW_HALF: be_pattern = tok_i.elem[0] ? 4'b1100 : 4'b0011;
            SEW_WORD: be_pattern = 4'b1111;
            default:  be_pattern = 4'b0000;
        endcase
    end

    // Lanes without an element keep their bytes
    always_comb begin
        for (int l = 0; l < VLANE_NUM; l++) begin
            if (tok_i.valid && tok_i.lane_mask[l]) begin
                bwen_o[l] = be_pattern;
            end else begin
                bwen_o[l] = 4'b0000;
            end
        end
    end

    //////////////////////////////
    // VRF and mask register ports
    //////////////////////////////
    assign wen_o       = tok_i.valid;
    assign waddr_o     = act_cmd_i.waddr + word_offset(act_cmd_i.sew, tok_i.elem);
    assign vmrf_addr_o = tok_i.elem;                 // One mask bit per element
    assign vmrf_wen_o  = wen_o & act_cmd_i.vector_mask;

    a_bwen_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        !wen_o |-> (bwen_o == '0));

    for (genvar l = 0; l < VLANE_NUM; l++) begin : g_byte_chk
        a_byte_onehot: assert property (@(posedge clk_i) disable iff (!rst_i)
            wen_o && (act_cmd_i.sew == SEW_BYTE) |-> $onehot0(bwen_o[l]));
    end

endmodule

// ==== sublane_driver.sv ====
`timescale 1ns/1ps

module sublane_driver #(
    parameter int PIPE_DELAY = 4
) (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  logic                                    start_i,
    input  sublane_pkg::vec_cmd_t                   cmd_i,
    output logic                                    ready_o,
    output logic                                    rd_valid_o,
    output logic [sublane_pkg::VLANE_NUM-1:0]       rd_lane_valid_o,
    output logic [sublane_pkg::ADDR_W-1:0]          raddr1_o,
    output logic [sublane_pkg::ADDR_W-1:0]          raddr2_o,
    output logic                                    store_valid_o,
    output logic                                    wen_o,
    output logic [sublane_pkg::ADDR_W-1:0]          waddr_o,
    output logic [sublane_pkg::VLANE_NUM-1:0][3:0]  bwen_o,
    output logic                                    vmrf_wen_o,
    output logic [sublane_pkg::ELEM_W-1:0]          vmrf_addr_o
);

    import sublane_pkg::*;

    vec_cmd_t  act_cmd;
    wr_token_t issue_tok;
    wr_token_t wr_tok;                               // Token at write time

    element_sequencer #(.PIPE_DELAY(PIPE_DELAY)) i_seq (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .start_i         (start_i),
        .cmd_i           (cmd_i),
        .ready_o         (ready_o),
        .act_cmd_o       (act_cmd),
        .rd_valid_o      (rd_valid_o),
        .rd_lane_valid_o (rd_lane_valid_o),
        .raddr1_o        (raddr1_o),
        .raddr2_o        (raddr2_o),
        .store_valid_o   (store_valid_o),
        .issue_tok_o     (issue_tok)
    );

    write_delay_line #(.PIPE_DELAY(PIPE_DELAY)) i_dly (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .tok_i (issue_tok),
        .tok_o (wr_tok)
    );

    write_port_gen i_wr (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .act_cmd_i   (act_cmd),
        .tok_i       (wr_tok),
        .wen_o       (wen_o),
        .waddr_o     (waddr_o),
        .bwen_o      (bwen_o),
        .vmrf_wen_o  (vmrf_wen_o),
        .vmrf_addr_o (vmrf_addr_o)
    );

endmodule

// ==== tb_sublane_driver.sv ====
`timescale 1ns/1ps

module tb_sublane_driver;

    import sublane_pkg::*;

    localparam int PIPE_DELAY = 4;
    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 5;

    typedef struct {
        inst_type_e        op;
        sew_e              sew;
        int                vl;
        logic [ADDR_W-1:0] raddr1;
        logic [ADDR_W-1:0] raddr2;
        logic [ADDR_W-1:0] waddr;
        logic              mask;
        int                exp_n;                    // Elements per lane
    } row_t;

    logic                          clk_i, rst_i, start_i;
    vec_cmd_t                      cmd_i;
    logic                          ready_o, rd_valid_o, store_valid_o, wen_o, vmrf_wen_o;
    logic [VLANE_NUM-1:0]          rd_lane_valid_o;
    logic [ADDR_W-1:0]             raddr1_o, raddr2_o, waddr_o;
    logic [VLANE_NUM-1:0][3:0]     bwen_o;
    logic [ELEM_W-1:0]             vmrf_addr_o;

    row_t        rows[$];
    logic [31:0] lfsr_q;
    int          err_cnt;
    int          chk_cnt;
    bit          table_built;

    sublane_driver #(.PIPE_DELAY(PIPE_DELAY)) i_dut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    //////////////////////////////
    // Random source
    //////////////////////////////
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_step(lfsr_q);                  // One step per bit
        end
    endtask

    //////////////////////////////
    // Reference rules
    //////////////////////////////
    function automatic logic [ADDR_W-1:0] word_of(sew_e sew, int k);
        case (sew)
            SEW_BYTE: return ADDR_W'(k / 4);
            SEW_HALF: return ADDR_W'(k / 2);
            default:  return ADDR_W'(k);
        endcase
    endfunction

    function automatic logic [VLANE_NUM-1:0] lanes_of(int vl, int k);
        logic [VLANE_NUM-1:0] m;
        for (int l = 0; l < VLANE_NUM; l++) m[l] = (k * VLANE_NUM + l) < vl;
        return m;
    endfunction

    function automatic logic [VLANE_NUM-1:0][3:0] bwen_of(sew_e sew, int vl, int k);
        logic [VLANE_NUM-1:0][3:0] be;
        logic [VLANE_NUM-1:0]      lanes;
        logic [3:0]                pat;
        lanes = lanes_of(vl, k);
        case (sew)
            SEW_BYTE: pat = 4'b0001 << (k % 4);
            SEW_HALF: pat = (k % 2 == 1) ? 4'b1100 : 4'b0011;
            default:  pat = 4'b1111;
        endcase
        for (int l = 0; l < VLANE_NUM; l++) be[l] = lanes[l] ? pat : 4'b0000;
        return be;
    endfunction

    function automatic int ready_edge(row_t r);
        return (r.op == INST_STORE) ? r.exp_n : r.exp_n + PIPE_DELAY;
    endfunction

    task automatic check_value(input bit ok, input string msg);
        chk_cnt++;
        assert (ok) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            err_cnt++;
        end
    endtask

    // vl of 0 draws the length from the LFSR
    task automatic add_row(input inst_type_e op, input sew_e sew, input int vl, input int r1,
                           input int r2, input int w, input bit mask, input int n);
        row_t r;
        int   v;
        r.op = op;
        r.sew = sew;
        r.raddr1 = ADDR_W'(r1);
        r.raddr2 = ADDR_W'(r2);
        r.waddr = ADDR_W'(w);
        r.mask = mask;
        r.vl = vl;
        r.exp_n = n;
        if (vl == 0) begin
            take_bits(7, v);
            r.vl = v + 1;                                // 1 to 128
            r.exp_n = (r.vl + VLANE_NUM - 1) / VLANE_NUM;
        end
        rows.push_back(r);
    endtask

    // j counts cycles after the acceptance edge
    task automatic check_cycle(input row_t r, input int j);
        bit is_rd;
        bit is_wr;
        int k;
        is_rd = (j < r.exp_n);
        k = j - PIPE_DELAY;
        is_wr = (r.op == INST_NORMAL) && (k >= 0) && (k < r.exp_n);
        check_value(ready_o == (j >= ready_edge(r)),
                    $sformatf("ready_o=%0b cycle %0d", ready_o, j));
        check_value(rd_valid_o == is_rd, $sformatf("rd_valid_o=%0b cycle %0d", rd_valid_o, j));
        check_value(store_valid_o == (is_rd && r.op == INST_STORE),
                    $sformatf("store_valid_o=%0b cycle %0d", store_valid_o, j));
        check_value(rd_lane_valid_o == (is_rd ? lanes_of(r.vl, j) : '0),
                    $sformatf("rd_lane_valid_o=%h cycle %0d", rd_lane_valid_o, j));
        if (is_rd) begin
            check_value(raddr1_o == ADDR_W'(r.raddr1 + word_of(r.sew, j)),
                        $sformatf("raddr1_o=%0d elem %0d", raddr1_o, j));
            check_value(raddr2_o == ADDR_W'(r.raddr2 + word_of(r.sew, j)),
                        $sformatf("raddr2_o=%0d elem %0d", raddr2_o, j));
        end
        check_value(wen_o == is_wr, $sformatf("wen_o=%0b cycle %0d", wen_o, j));
        check_value(vmrf_wen_o == (is_wr && r.mask), $sformatf("vmrf_wen_o=%0b", vmrf_wen_o));
        check_value(bwen_o == (is_wr ? bwen_of(r.sew, r.vl, k) : '0),
                    $sformatf("bwen_o=%h cycle %0d", bwen_o, j));
        if (is_wr) begin
            check_value(waddr_o == ADDR_W'(r.waddr + word_of(r.sew, k)),
                        $sformatf("waddr_o=%0d elem %0d", waddr_o, k));
            check_value(vmrf_addr_o == ELEM_W'(k),
                        $sformatf("vmrf_addr_o=%0d elem %0d", vmrf_addr_o, k));
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        vec_cmd_t cmd;
        int       row_err;
        int       j;
        clk_i = 1'b0;
        rst_i = 1'b0;
        start_i = 1'b0;
        cmd_i = '0;
        err_cnt = 0;
        chk_cnt = 0;
        lfsr_q = 32'hd7db_197e;
        add_row(INST_NORMAL, SEW_BYTE,  64,  10, 100, 200, 1'b1,  8);
        add_row(INST_NORMAL, SEW_HALF,  21,   3,  40, 300, 1'b0,  3);   // Partial last element
        add_row(INST_NORMAL, SEW_WORD,   8,   0,   1,   2, 1'b1,  1);
        add_row(INST_STORE,  SEW_BYTE,  37,  50,  60,  70, 1'b0,  5);
        add_row(INST_STORE,  SEW_WORD, 128, 505,   0,   0, 1'b0, 16);   // Read address wraps
        add_row(INST_NORMAL, SEW_WORD, 200,  20,  30, 500, 1'b1, 25);
        add_row(INST_NORMAL, SEW_BYTE,   0,   7,   8,   9, 1'b1,  0);
        add_row(INST_STORE,  SEW_HALF,   0,  11,  12,  13, 1'b0,  0);
        add_row(INST_NORMAL, SEW_HALF,   0,  14,  15,  16, 1'b0,  0);
        add_row(INST_NORMAL, SEW_BYTE,   1, 400, 401, 402, 1'b1,  1);
        table_built = 1'b1;

        repeat (RST_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b1;
        @(negedge clk_i);
        check_value(ready_o && !rd_valid_o && !store_valid_o && !wen_o && !vmrf_wen_o
                    && bwen_o == '0, "outputs not idle after reset");
        $display("reset: %0d errors", err_cnt);

        foreach (rows[i]) begin
            row_err = err_cnt;
            cmd.inst_type = rows[i].op;
            cmd.sew = rows[i].sew;
            cmd.vl = VL_W'(rows[i].vl);
            cmd.raddr1 = rows[i].raddr1;
            cmd.raddr2 = rows[i].raddr2;
            cmd.waddr = rows[i].waddr;
            cmd.vector_mask = rows[i].mask;
            start_i = 1'b1;
            cmd_i = cmd;
            @(negedge clk_i);
            start_i = 1'b0;
            cmd_i = ~cmd;                                // Only the accept edge may see cmd_i
            j = 0;
            check_cycle(rows[i], j);
            while (!ready_o) begin
                j++;
                @(negedge clk_i);
                check_cycle(rows[i], j);
            end
            check_value(j == ready_edge(rows[i]), $sformatf("ready_o rose after %0d cycles", j));
            $display("row %0d: %s %s vl=%0d N=%0d: %0d errors", i, rows[i].op.name(),
                     rows[i].sew.name(), rows[i].vl, rows[i].exp_n, err_cnt - row_err);
        end

        $display("Done: %0d rows, %0d checks, %0d errors", rows.size(), chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        longint limit;
        wait (table_built);
        limit = RST_CYCLES;
        foreach (rows[i]) limit += rows[i].exp_n + PIPE_DELAY + 10;
        #(limit * CLK_PERIOD);
        $display("Timeout: the DUT did not return to ready within %0d cycles", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
sublane_pkg.sv
element_sequencer.sv
write_delay_line.sv
write_port_gen.sv
sublane_driver.sv
tb_sublane_driver.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sublane_driver
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert --timing -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary -j 0 $(VFLAGS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
